// ==== hw/lc4_config.svh ====
`ifndef LC4_CONFIG_SVH
`define LC4_CONFIG_SVH

// datapath widths
`define LC4_WORD_W   16      // data and insn word
`define LC4_SEL_W    3       // register select
`define LC4_NREGS    8       // r0..r7

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// opcodes, insn[15:12]
`define LC4_OP_BR    4'b0000
`define LC4_OP_ARITH 4'b0001 // add, sub, add imm5
`define LC4_OP_LOGIC 4'b0101 // and, or, xor, and imm5
`define LC4_OP_LDR   4'b0110
`define LC4_OP_STR   4'b0111
`define LC4_OP_CONST 4'b1001

`endif

// ==== hw/lc4_pkg.sv ====
`default_nettype none

`include "lc4_config.svh"

package lc4_pkg;

   // register form: op rd rs sub rt
   typedef struct packed {
      logic [3:0]            opcode;
      logic [`LC4_SEL_W-1:0] rd;
      logic [`LC4_SEL_W-1:0] rs;
      logic [2:0]            sub;  // alu sub-op, bit 2 set means imm5 form
      logic [`LC4_SEL_W-1:0] rt;
   } lc4_rtype_s;

   // immediate form: op rd rs imm6, imm6[5] doubles as the imm5 flag
   typedef struct packed {
      logic [3:0]            opcode;
      logic [`LC4_SEL_W-1:0] rd;   // rt for str
      logic [`LC4_SEL_W-1:0] rs;
      logic [5:0]            imm6;
   } lc4_itype_s;

   // one word, two readings
   typedef union packed {
      lc4_rtype_s r;
      lc4_itype_s i;
   } lc4_insn_u;

endpackage

`default_nettype wire

// ==== hw/lc4_stage_if.sv ====
`default_nettype none

`include "lc4_config.svh"

// decode -> execute bundle
interface lc4_dx_if;
   logic [`LC4_WORD_W-1:0] pc_plus_one;  // from fetch
   logic [`LC4_WORD_W-1:0] insn;
   logic [`LC4_WORD_W-1:0] rs_data;
   logic [`LC4_WORD_W-1:0] rt_data;
   logic [`LC4_SEL_W-1:0]  rs_sel;
   logic [`LC4_SEL_W-1:0]  rt_sel;
   logic [`LC4_SEL_W-1:0]  rd_sel;
   logic                   rs_re;
   logic                   rt_re;
   logic                   regfile_we;
   logic                   nzp_we;
   logic                   is_load;
   logic                   is_store;
   logic                   is_branch;
   logic                   valid;        // from fetch

   // fetch drives pc_plus_one and valid, decoder the rest
   modport dec (output pc_plus_one, insn, rs_data, rt_data, rs_sel, rt_sel, rd_sel,
                rs_re, rt_re, regfile_we, nzp_we, is_load, is_store, is_branch, valid);
   modport exe (input pc_plus_one, insn, rs_data, rt_data, rs_sel, rt_sel, rd_sel,
                rs_re, rt_re, regfile_we, nzp_we, is_load, is_store, is_branch, valid);
   modport haz (input rs_sel, rt_sel, rs_re, rt_re, is_branch);
endinterface

// execute <-> memory/writeback
interface lc4_xm_if;
   logic [`LC4_WORD_W-1:0] alu_result, store_data, pc;
   logic [`LC4_SEL_W-1:0]  rd_sel;
   logic                   regfile_we, nzp_we, is_load, is_store, valid;
   // return path for bypass and branch
   logic                   m_we, w_we;
   logic [`LC4_SEL_W-1:0]  m_sel, w_sel;
   logic [`LC4_WORD_W-1:0] m_data, w_data;
   logic [2:0]             nzp_eff;

   modport exe (output alu_result, store_data, pc, rd_sel, regfile_we, nzp_we, is_load,
                is_store, valid,
                input m_we, m_sel, m_data, w_we, w_sel, w_data, nzp_eff);
   modport mw (input alu_result, store_data, pc, rd_sel, regfile_we, nzp_we, is_load,
               is_store, valid,
               output m_we, m_sel, m_data, w_we, w_sel, w_data, nzp_eff);
endinterface

`default_nettype wire

// ==== hw/lc4_fetch.sv ====
`default_nettype none

`include "lc4_config.svh"

module lc4_fetch (
   input  wire                   gwe,
   input  wire                   i_reset,
   input  wire                   i_stall,    // load-use, hold pc and f/d
   input  wire                   i_taken,    // branch resolved taken in x
   input  wire [`LC4_WORD_W-1:0] i_target,
   input  wire [`LC4_WORD_W-1:0] i_insn,     // imem read data
   output logic [`LC4_WORD_W-1:0] o_pc,
   output logic [`LC4_WORD_W-1:0] o_d_insn,
   lc4_dx_if.dec                 dx
);

   logic [`LC4_WORD_W-1:0] pc_plus_one;
   logic [`LC4_WORD_W-1:0] d_pc_plus_one;
   logic                   d_valid;

   assign pc_plus_one = o_pc + 1'b1;

   // pc register
   always_ff @(posedge gwe) begin
      if (i_reset) o_pc <= `LC4_RESET_PC;
      else if (i_taken) o_pc <= i_target;  // redirect wins over stall
      else if (!i_stall) o_pc <= pc_plus_one;
   end

   // f/d valid, a flush drops the slot being fetched
   always_ff @(posedge gwe) begin
      if (i_reset) d_valid <= 1'b0;
      else if (i_taken) d_valid <= 1'b0;
      else if (!i_stall) d_valid <= 1'b1;
   end

   // f/d payload
   always_ff @(posedge gwe) begin
      if (!i_stall) begin
         o_d_insn      <= i_insn;
         d_pc_plus_one <= pc_plus_one;
      end
   end

   assign dx.pc_plus_one = d_pc_plus_one;
   assign dx.valid       = d_valid;

endmodule

`default_nettype wire

// ==== hw/lc4_decoder.sv ====
`default_nettype none

`include "lc4_config.svh"

module lc4_decoder (
   input  lc4_pkg::lc4_insn_u     i_insn,
   lc4_dx_if.dec                  dx,
   output logic [`LC4_SEL_W-1:0]  o_rs_sel,   // to regfile read ports
   output logic [`LC4_SEL_W-1:0]  o_rt_sel,
   input  wire [`LC4_WORD_W-1:0]  i_rs_data,
   input  wire [`LC4_WORD_W-1:0]  i_rt_data
);

   logic [3:0] op;
   logic [2:0] sub;
   logic       imm_form;
   logic       arith_ok, logic_ok, alu_ok;
   logic       is_ldr, is_str, is_const, is_br;

   assign op       = i_insn.r.opcode;
   assign sub      = i_insn.r.sub;
   assign imm_form = i_insn.i.imm6[5];        // imm5 forms of add / and

   // only add, sub, add imm
   assign arith_ok = (op == `LC4_OP_ARITH) &&
                     (imm_form || sub == 3'b000 || sub == 3'b010);
   // only and, or, xor, and imm, not is dropped
   assign logic_ok = (op == `LC4_OP_LOGIC) &&
                     (imm_form || sub == 3'b000 || sub == 3'b010 || sub == 3'b011);
   assign alu_ok   = arith_ok || logic_ok;

   assign is_ldr   = (op == `LC4_OP_LDR);
   assign is_str   = (op == `LC4_OP_STR);
   assign is_const = (op == `LC4_OP_CONST);
   assign is_br    = (op == `LC4_OP_BR);

   // str keeps its data register in [11:9]
   assign o_rs_sel = i_insn.r.rs;
   assign o_rt_sel = is_str ? i_insn.i.rd : i_insn.r.rt;

   assign dx.insn    = i_insn;
   assign dx.rs_data = i_rs_data;                // already wd-bypassed
   assign dx.rt_data = i_rt_data;
   assign dx.rs_sel  = o_rs_sel;
   assign dx.rt_sel  = o_rt_sel;
   assign dx.rd_sel  = i_insn.r.rd;

   assign dx.rs_re = alu_ok || is_ldr || is_str;
   assign dx.rt_re = (alu_ok && !imm_form) || is_str;

   // anything unsupported falls out here with no writes
   assign dx.regfile_we = alu_ok || is_ldr || is_const;
   assign dx.nzp_we     = alu_ok || is_ldr || is_const;  // nzp follows every reg write
   assign dx.is_load    = is_ldr;
   assign dx.is_store   = is_str;
   assign dx.is_branch  = is_br;

endmodule

`default_nettype wire

// ==== hw/lc4_regfile.sv ====
`default_nettype none

`include "lc4_config.svh"

module lc4_regfile (
   input  wire                    gwe,
   input  wire                    i_reset,
   input  wire [`LC4_SEL_W-1:0]   i_rs,
   input  wire [`LC4_SEL_W-1:0]   i_rt,
   output logic [`LC4_WORD_W-1:0] o_rs_data,
   output logic [`LC4_WORD_W-1:0] o_rt_data,
   input  wire [`LC4_SEL_W-1:0]   i_rd,
   input  wire [`LC4_WORD_W-1:0]  i_wdata,
   input  wire                    i_we
);

   logic [`LC4_WORD_W-1:0] regs [`LC4_NREGS];

   always_ff @(posedge gwe) begin
      if (i_reset) regs <= '{default: '0};
      else if (i_we) regs[i_rd] <= i_wdata;
   end

   // wd bypass: a same-cycle write shows up on the read
   assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

   // a write always names one of the eight registers
   a_write_sel: assert property (@(posedge gwe) disable iff (i_reset)
      i_we |-> !$isunknown(i_rd));

endmodule

`default_nettype wire

// ==== hw/lc4_execute.sv ====
`default_nettype none

`include "lc4_config.svh"

module lc4_execute (
   input  wire                    gwe,
   input  wire                    i_reset,
   input  wire                    i_bubble,   // stall or flush, insert a nop
   lc4_dx_if.exe                  dx,
   lc4_xm_if.exe                  xm,
   output logic                   o_taken,
   output logic [`LC4_WORD_W-1:0] o_target,
   output logic                   o_x_load,
   output logic [`LC4_SEL_W-1:0]  o_x_rd
);

   import lc4_pkg::*;

   localparam int W = `LC4_WORD_W;

   lc4_insn_u            x_insn;
   logic [W-1:0]         x_pc_plus_one, x_rs_data, x_rt_data;
   logic [`LC4_SEL_W-1:0] x_rs_sel, x_rt_sel, x_rd_sel;
   logic                 x_valid, x_rs_re, x_rt_re, x_regfile_we, x_nzp_we;
   logic                 x_is_load, x_is_store, x_is_branch;
   logic                 keep;
   logic [W-1:0]         rs_val, rt_val, alu;
   logic [W-1:0]         imm5, imm6, imm9;

   assign keep = dx.valid && !i_bubble;

   // x control, bubble clears all of it
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         x_valid      <= 1'b0;
         x_rs_re      <= 1'b0;
         x_rt_re      <= 1'b0;
         x_regfile_we <= 1'b0;
         x_nzp_we     <= 1'b0;
         x_is_load    <= 1'b0;
         x_is_store   <= 1'b0;
         x_is_branch  <= 1'b0;
      end else begin
         x_valid      <= keep;
         x_rs_re      <= keep && dx.rs_re;
         x_rt_re      <= keep && dx.rt_re;
         x_regfile_we <= keep && dx.regfile_we;
         x_nzp_we     <= keep && dx.nzp_we;
         x_is_load    <= keep && dx.is_load;
         x_is_store   <= keep && dx.is_store;
         x_is_branch  <= keep && dx.is_branch;
      end
   end

   // x payload
   always_ff @(posedge gwe) begin
      x_insn        <= dx.insn;
      x_pc_plus_one <= dx.pc_plus_one;
      x_rs_data     <= dx.rs_data;
      x_rt_data     <= dx.rt_data;
      x_rs_sel      <= dx.rs_sel;
      x_rt_sel      <= dx.rt_sel;
      x_rd_sel      <= dx.rd_sel;
   end

   // mx has priority over wx, it is the younger value
   assign rs_val = (x_rs_re && xm.m_we && xm.m_sel == x_rs_sel) ? xm.m_data :
                   (x_rs_re && xm.w_we && xm.w_sel == x_rs_sel) ? xm.w_data : x_rs_data;
   assign rt_val = (x_rt_re && xm.m_we && xm.m_sel == x_rt_sel) ? xm.m_data :
                   (x_rt_re && xm.w_we && xm.w_sel == x_rt_sel) ? xm.w_data : x_rt_data;

   // sign-extended immediates
   assign imm5 = {{(W-5){x_insn.i.imm6[4]}}, x_insn.i.imm6[4:0]};
   assign imm6 = {{(W-6){x_insn.i.imm6[5]}}, x_insn.i.imm6};
   assign imm9 = {{(W-9){x_insn[8]}}, x_insn[8:0]};        // br and const

   always_comb begin
      alu = '0;
      case (x_insn.r.opcode)
         `LC4_OP_ARITH: begin
            if (x_insn.i.imm6[5]) alu = rs_val + imm5;
            else if (x_insn.r.sub == 3'b010) alu = rs_val - rt_val;
            else alu = rs_val + rt_val;
         end
         `LC4_OP_LOGIC: begin
            if (x_insn.i.imm6[5]) alu = rs_val & imm5;
            else if (x_insn.r.sub == 3'b010) alu = rs_val | rt_val;
            else if (x_insn.r.sub == 3'b011) alu = rs_val ^ rt_val;
            else alu = rs_val & rt_val;
         end
         `LC4_OP_LDR, `LC4_OP_STR: alu = rs_val + imm6;    // effective address
         `LC4_OP_CONST: alu = imm9;
         `LC4_OP_BR: alu = x_pc_plus_one + imm9;            // branch target
         default: alu = '0;
      endcase
   end

   // taken when the mask hits the current nzp
   assign o_taken  = x_is_branch && |(x_insn[11:9] & xm.nzp_eff);
   assign o_target = alu;
   assign o_x_load = x_is_load;
   assign o_x_rd   = x_rd_sel;

   assign xm.alu_result = alu;
   assign xm.store_data = rt_val;
   assign xm.pc         = x_pc_plus_one - 1'b1;   // trace pc
   assign xm.rd_sel     = x_rd_sel;
   assign xm.regfile_we = x_regfile_we;
   assign xm.nzp_we     = x_nzp_we;
   assign xm.is_load    = x_is_load;
   assign xm.is_store   = x_is_store;
   assign xm.valid      = x_valid;

   // a taken branch is live here, and the slot behind it comes in flushed
   a_taken_flush: assert property (@(posedge gwe) disable iff (i_reset)
      o_taken |-> x_valid ##1 (!x_valid && !o_taken));

endmodule

`default_nettype wire

// ==== hw/lc4_memwb.sv ====
`default_nettype none

`include "lc4_config.svh"

module lc4_memwb (
   input  wire                    gwe,
   input  wire                    i_reset,
   lc4_xm_if.mw                   xm,
   output logic [`LC4_WORD_W-1:0] o_dmem_addr,
   output logic                   o_dmem_we,
   output logic [`LC4_WORD_W-1:0] o_dmem_towrite,
   input  wire [`LC4_WORD_W-1:0]  i_dmem_data,
   output logic                   o_wb_valid,
   output logic                   o_wb_we,
   output logic [`LC4_SEL_W-1:0]  o_wb_sel,
   output logic [`LC4_WORD_W-1:0] o_wb_data,
   output logic [`LC4_WORD_W-1:0] o_wb_pc
);

   logic [`LC4_WORD_W-1:0] m_alu, m_store, m_pc, m_data;
   logic [`LC4_SEL_W-1:0]  m_sel;
   logic                   m_valid, m_we, m_nzp_we, m_is_load, m_is_store;
   logic [2:0]             m_nzp, nzp_reg;

   // m stage control
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         m_valid    <= 1'b0;
         m_we       <= 1'b0;
         m_nzp_we   <= 1'b0;
         m_is_load  <= 1'b0;
         m_is_store <= 1'b0;
      end else begin
         m_valid    <= xm.valid;
         m_we       <= xm.regfile_we;
         m_nzp_we   <= xm.nzp_we;
         m_is_load  <= xm.is_load;
         m_is_store <= xm.is_store;
      end
   end

   always_ff @(posedge gwe) begin
      m_alu   <= xm.alu_result;
      m_store <= xm.store_data;
      m_sel   <= xm.rd_sel;
      m_pc    <= xm.pc;
   end

   // dmem is combinational, load data comes back this cycle
   assign o_dmem_addr    = m_alu;
   assign o_dmem_we      = m_is_store;
   assign o_dmem_towrite = m_store;

   assign m_data = m_is_load ? i_dmem_data : m_alu;
   assign m_nzp  = m_data[`LC4_WORD_W-1] ? 3'b100 :
                   (m_data == '0)        ? 3'b010 : 3'b001;

   // w stage, nzp reg loads as the writer moves into w
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_wb_valid <= 1'b0;
         o_wb_we    <= 1'b0;
         nzp_reg    <= 3'b000;
      end else begin
         o_wb_valid <= m_valid;
         o_wb_we    <= m_we;
         if (m_nzp_we) nzp_reg <= m_nzp;
      end
   end

   always_ff @(posedge gwe) begin
      o_wb_sel  <= m_sel;
      o_wb_data <= m_data;
      o_wb_pc   <= m_pc;
   end

   assign xm.m_we    = m_we;
   assign xm.m_sel   = m_sel;
   assign xm.m_data  = m_data;     // mx bypass source
   assign xm.w_we    = o_wb_we;
   assign xm.w_sel   = o_wb_sel;
   assign xm.w_data  = o_wb_data;  // wx bypass source
   assign xm.nzp_eff = m_nzp_we ? m_nzp : nzp_reg;

endmodule

`default_nettype wire

// ==== hw/lc4_hazard_ctrl.sv ====
`default_nettype none

`include "lc4_config.svh"

module lc4_hazard_ctrl (
   lc4_dx_if.haz                 dx,
   input  wire                   i_x_load,   // valid load sitting in x
   input  wire [`LC4_SEL_W-1:0]  i_x_rd,
   input  wire                   i_taken,
   output logic                  o_stall,
   output logic                  o_bubble
);

   logic rs_hit, rt_hit, load_use;

   assign rs_hit = dx.rs_re && (dx.rs_sel == i_x_rd);
   assign rt_hit = dx.rt_re && (dx.rt_sel == i_x_rd);  // also catches str data

   // br needs nzp of the load, which only exists once it reaches m
   assign load_use = i_x_load && (rs_hit || rt_hit || dx.is_branch);

   assign o_stall  = load_use && !i_taken;   // the flush already kills decode
   assign o_bubble = o_stall || i_taken;

endmodule

`default_nettype wire

// ==== hw/lc4_processor.sv ====
`default_nettype none

`include "lc4_config.svh"

module lc4_processor (
   input  wire                    gwe,             // pipeline clock
   input  wire                    i_reset,
   output logic [`LC4_WORD_W-1:0] o_cur_pc,        // imem address
   input  wire [`LC4_WORD_W-1:0]  i_cur_insn,
   output logic [`LC4_WORD_W-1:0] o_dmem_addr,
   output logic                   o_dmem_we,
   output logic [`LC4_WORD_W-1:0] o_dmem_towrite,
   input  wire [`LC4_WORD_W-1:0]  i_dmem_data,
   output logic                   o_wb_valid,      // one pulse per retirement
   output logic                   o_wb_we,
   output logic [`LC4_SEL_W-1:0]  o_wb_sel,
   output logic [`LC4_WORD_W-1:0] o_wb_data,
   output logic [`LC4_WORD_W-1:0] o_wb_pc
);

   logic                   stall, bubble, taken, x_load;
   logic [`LC4_WORD_W-1:0] target, d_insn, rs_data, rt_data;
   logic [`LC4_SEL_W-1:0]  x_rd, rs_sel, rt_sel;

   lc4_dx_if dx ();
   lc4_xm_if xm ();

   lc4_fetch u_fetch (
      .gwe      (gwe),
      .i_reset  (i_reset),
      .i_stall  (stall),
      .i_taken  (taken),
      .i_target (target),
      .i_insn   (i_cur_insn),
      .o_pc     (o_cur_pc),
      .o_d_insn (d_insn),
      .dx       (dx.dec)
   );

   lc4_decoder u_decoder (
      .i_insn    (d_insn),
      .dx        (dx.dec),
      .o_rs_sel  (rs_sel),
      .o_rt_sel  (rt_sel),
      .i_rs_data (rs_data),
      .i_rt_data (rt_data)
   );

   // written from w, read in d
   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_rs      (rs_sel),
      .i_rt      (rt_sel),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_rd      (o_wb_sel),
      .i_wdata   (o_wb_data),
      .i_we      (o_wb_we)
   );

   lc4_execute u_execute (
      .gwe      (gwe),
      .i_reset  (i_reset),
      .i_bubble (bubble),
      .dx       (dx.exe),
      .xm       (xm.exe),
      .o_taken  (taken),
      .o_target (target),
      .o_x_load (x_load),
      .o_x_rd   (x_rd)
   );

   lc4_memwb u_memwb (
      .gwe            (gwe),
      .i_reset        (i_reset),
      .xm             (xm.mw),
      .o_dmem_addr    (o_dmem_addr),
      .o_dmem_we      (o_dmem_we),
      .o_dmem_towrite (o_dmem_towrite),
      .i_dmem_data    (i_dmem_data),
      .o_wb_valid     (o_wb_valid),
      .o_wb_we        (o_wb_we),
      .o_wb_sel       (o_wb_sel),
      .o_wb_data      (o_wb_data),
      .o_wb_pc        (o_wb_pc)
   );

   lc4_hazard_ctrl u_hazard (
      .dx       (dx.haz),
      .i_x_load (x_load),
      .i_x_rd   (x_rd),
      .i_taken  (taken),
      .o_stall  (stall),
      .o_bubble (bubble)
   );

endmodule

`default_nettype wire

// ==== verification/lc4_tb.sv ====
`default_nettype none

`include "lc4_config.svh"

module lc4_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int W      = `LC4_WORD_W;
   localparam int NTESTS = 5;
   localparam int MAXI   = 16;   // program slots per test
   localparam int MAXR   = 16;   // retirements per test
   localparam int MAXS   = 4;    // stores per test

   logic                  gwe;
   logic                  i_reset;
   logic [W-1:0]          o_cur_pc, i_cur_insn;
   logic [W-1:0]          o_dmem_addr, o_dmem_towrite, i_dmem_data;
   logic                  o_dmem_we, o_wb_valid, o_wb_we;
   logic [`LC4_SEL_W-1:0] o_wb_sel;
   logic [W-1:0]          o_wb_data, o_wb_pc;

   logic [W-1:0] imem [0:65535];
   logic [W-1:0] dmem [0:65535];

   // test table, one row per program
   string                 tname  [NTESTS];
   int                    n_insn [NTESTS];
   logic [W-1:0]          prog   [NTESTS][MAXI];
   int                    n_ret  [NTESTS];
   logic                  r_we   [NTESTS][MAXR];
   logic [`LC4_SEL_W-1:0] r_sel  [NTESTS][MAXR];
   logic [W-1:0]          r_data [NTESTS][MAXR];
   logic [W-1:0]          r_pc   [NTESTS][MAXR];  // slot address of the retiring insn
   logic                  r_gap  [NTESTS][MAXR];  // bubble cycle right before this one
   int                    n_st   [NTESTS];
   logic [W-1:0]          s_addr [NTESTS][MAXS];
   logic [W-1:0]          s_data [NTESTS][MAXS];

   int   row, cur, ret_cnt, st_cnt, cycle, last_ret, errors, failed, total_insn;
   logic running, table_done;

   lc4_processor dut0 (
      .gwe            (gwe),
      .i_reset        (i_reset),
      .o_cur_pc       (o_cur_pc),
      .i_cur_insn     (i_cur_insn),
      .o_dmem_addr    (o_dmem_addr),
      .o_dmem_we      (o_dmem_we),
      .o_dmem_towrite (o_dmem_towrite),
      .i_dmem_data    (i_dmem_data),
      .o_wb_valid     (o_wb_valid),
      .o_wb_we        (o_wb_we),
      .o_wb_sel       (o_wb_sel),
      .o_wb_data      (o_wb_data),
      .o_wb_pc        (o_wb_pc)
   );

   always #20 gwe = ~gwe;   // 40 ns period

   // both memories answer in the same cycle
   assign i_cur_insn  = imem[o_cur_pc];
   assign i_dmem_data = dmem[o_dmem_addr];

   // instruction encoders
   function automatic logic [W-1:0] rr_word(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                            logic [2:0] sub, logic [2:0] rt);
      return {op, rd, rs, sub, rt};
   endfunction

   function automatic logic [W-1:0] imm5_word(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                              logic [4:0] imm5);
      return {op, rd, rs, 1'b1, imm5};   // bit 5 flags the immediate form
   endfunction

   function automatic logic [W-1:0] mem_word(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                             logic [5:0] imm6);
      return {op, rd, rs, imm6};         // str puts its data register in rd
   endfunction

   function automatic logic [W-1:0] const_word(logic [2:0] rd, logic [8:0] imm9);
      return {`LC4_OP_CONST, rd, imm9};
   endfunction

   function automatic logic [W-1:0] br_word(logic [2:0] nzp, logic [8:0] off9);
      return {`LC4_OP_BR, nzp, off9};
   endfunction

   function automatic logic [W-1:0] sext(logic [W-1:0] v, int bits);
      logic [W-1:0] hi;
      hi = '1 << bits;
      return v[bits-1] ? (v | hi) : (v & ~hi);
   endfunction

   // preload pattern, every address bit matters
   function automatic logic [W-1:0] fill_value(logic [W-1:0] a);
      return {a[7:0], a[15:8]} ^ 16'h5A3C;
   endfunction

   task automatic report_mismatch(string sig, int item, logic [W-1:0] got, logic [W-1:0] want);
      $display("Mismatch %s: test %0d item %0d got 0x%h expected 0x%h",
               sig, cur + 1, item, got, want);
      errors++;
   endtask

   task automatic report_failure(string msg);
      $display("test %0d: %s", cur + 1, msg);
      errors++;
   endtask

   task automatic start_row(int t, string nm);
      row       = t;
      tname[t]  = nm;
      n_insn[t] = 0;
      n_ret[t]  = 0;
      n_st[t]   = 0;
   endtask

   // an instruction that must never retire
   task automatic add_insn(logic [W-1:0] w);
      prog[row][n_insn[row]] = w;
      n_insn[row]++;
   endtask

   task automatic add_retiring(logic [W-1:0] w, logic we, logic [2:0] sel,
                               logic [W-1:0] data, logic gap);
      r_pc[row][n_ret[row]]   = `LC4_RESET_PC + n_insn[row];
      add_insn(w);
      r_we[row][n_ret[row]]   = we;
      r_sel[row][n_ret[row]]  = sel;
      r_data[row][n_ret[row]] = data;
      r_gap[row][n_ret[row]]  = gap;
      n_ret[row]++;
   endtask

   task automatic expect_store(logic [W-1:0] a, logic [W-1:0] d);
      s_addr[row][n_st[row]] = a;
      s_data[row][n_st[row]] = d;
      n_st[row]++;
   endtask

   task automatic build_table();
      logic [8:0]   a9, b9;
      logic [W-1:0] va, vb, v3, v4, v5, v1, v2, ld, lm, st;
      a9 = $urandom % 512;   // random const operands
      b9 = $urandom % 512;
      va = sext(a9, 9);
      vb = sext(b9, 9);
      v3 = va + vb;
      v4 = v3 - va;
      v5 = v4 + sext(5'h1D, 5);
      start_row(0, "dependent arithmetic");
      add_retiring(const_word(1, a9), 1, 1, va, 0);
      add_retiring(const_word(2, b9), 1, 2, vb, 0);
      add_retiring(rr_word(`LC4_OP_ARITH, 3, 1, 3'b000, 2), 1, 3, v3, 0); // mx r2, wx r1
      add_retiring(rr_word(`LC4_OP_ARITH, 4, 3, 3'b010, 1), 1, 4, v4, 0); // r1 via wd
      add_retiring(imm5_word(`LC4_OP_ARITH, 5, 4, 5'h1D), 1, 5, v5, 0);   // add #-3
      add_retiring(rr_word(`LC4_OP_ARITH, 6, 5, 3'b000, 4), 1, 6, v5 + v4, 0);

      v1 = sext(9'h0F3, 9);
      v2 = sext(9'h1AB, 9);
      start_row(1, "logic and no-ops");
      add_retiring(const_word(1, 9'h0F3), 1, 1, v1, 0);
      add_retiring(const_word(2, 9'h1AB), 1, 2, v2, 0);
      add_retiring(rr_word(`LC4_OP_LOGIC, 3, 1, 3'b000, 2), 1, 3, v1 & v2, 0);
      add_retiring(rr_word(`LC4_OP_LOGIC, 4, 1, 3'b010, 2), 1, 4, v1 | v2, 0);
      add_retiring(rr_word(`LC4_OP_LOGIC, 5, 1, 3'b011, 2), 1, 5, v1 ^ v2, 0);
      add_retiring(imm5_word(`LC4_OP_LOGIC, 6, 2, 5'h0E), 1, 6, v2 & sext(5'h0E, 5), 0);
      add_retiring(16'hF0FF, 0, 0, 0, 0);                               // trap, dropped
      add_retiring(rr_word(`LC4_OP_ARITH, 1, 2, 3'b001, 3), 0, 0, 0, 0); // mul, dropped
      add_retiring(imm5_word(`LC4_OP_LOGIC, 7, 4, 5'h18), 1, 7, (v1 | v2) & sext(5'h18, 5), 0);
      add_retiring(rr_word(`LC4_OP_ARITH, 0, 1, 3'b000, 1), 1, 0, v1 + v1, 0); // r1 untouched

      ld = fill_value(16'h0045);
      lm = fill_value(16'h003E);
      start_row(2, "load-use");
      add_retiring(const_word(1, 9'h040), 1, 1, 16'h0040, 0);
      add_retiring(mem_word(`LC4_OP_LDR, 2, 1, 6'd5), 1, 2, ld, 0);
      add_retiring(rr_word(`LC4_OP_ARITH, 3, 2, 3'b000, 1), 1, 3, ld + 16'h0040, 1);
      add_retiring(mem_word(`LC4_OP_LDR, 4, 1, 6'h3E), 1, 4, lm, 0);      // offset -2
      add_retiring(rr_word(`LC4_OP_ARITH, 5, 1, 3'b010, 4), 1, 5, 16'h0040 - lm, 1);

      st = sext(9'h19C, 9);   // -100
      start_row(3, "store and reload");
      add_retiring(const_word(1, 9'h080), 1, 1, 16'h0080, 0);
      add_retiring(const_word(2, 9'h19C), 1, 2, st, 0);
      add_retiring(mem_word(`LC4_OP_STR, 2, 1, 6'd3), 0, 0, 0, 0);       // data by mx
      expect_store(16'h0083, st);
      add_retiring(const_word(3, 9'h007), 1, 3, 16'h0007, 0);
      add_retiring(mem_word(`LC4_OP_LDR, 4, 1, 6'd3), 1, 4, st, 0);
      add_retiring(rr_word(`LC4_OP_ARITH, 5, 4, 3'b000, 3), 1, 5, st + 16'h0007, 1);
      add_retiring(mem_word(`LC4_OP_LDR, 6, 1, 6'd3), 1, 6, st, 0);
      add_retiring(mem_word(`LC4_OP_STR, 6, 1, 6'd4), 0, 0, 0, 1);       // data from load
      expect_store(16'h0084, st);

      start_row(4, "branches");
      add_retiring(const_word(1, 9'h1FF), 1, 1, 16'hFFFF, 0);
      add_retiring(br_word(3'b100, 9'd2), 0, 0, 0, 0);    // brn on negative, taken
      add_insn(const_word(2, 9'h011));
      add_insn(const_word(3, 9'h022));
      add_retiring(const_word(4, 9'h000), 1, 4, 16'h0000, 0);
      add_retiring(br_word(3'b001, 9'd1), 0, 0, 0, 0);    // brp on zero falls through
      add_retiring(const_word(5, 9'h033), 1, 5, 16'h0033, 0);
      add_retiring(br_word(3'b011, 9'd2), 0, 0, 0, 0);    // brzp on positive, taken
      add_insn(const_word(6, 9'h044));
      add_insn(const_word(7, 9'h055));
      add_retiring(rr_word(`LC4_OP_ARITH, 6, 5, 3'b000, 5), 1, 6, 16'h0066, 0);
   endtask

   task automatic load_program(int t);
      for (int a = 0; a < 65536; a++) begin
         imem[a] = '0;   // br with empty mask, never taken
         dmem[a] = fill_value(a[W-1:0]);
      end
      for (int i = 0; i < n_insn[t]; i++)
         imem[`LC4_RESET_PC + i] = prog[t][i];
   endtask

   task automatic check_reset_state(int c);
      assert (o_cur_pc === `LC4_RESET_PC)
         else report_mismatch("o_cur_pc", c, o_cur_pc, `LC4_RESET_PC);
      assert (o_dmem_we === 1'b0) else report_mismatch("o_dmem_we", c, o_dmem_we, 0);
      assert (o_wb_valid === 1'b0) else report_mismatch("o_wb_valid", c, o_wb_valid, 0);
   endtask

   // four edges with reset high, last check is the first cycle out of reset
   task automatic apply_reset();
      for (int c = 0; c < 4; c++) begin
         @(posedge gwe);
         #2;
         if (c == 3) i_reset = 1'b0;
         @(negedge gwe);
         check_reset_state(c);
      end
   endtask

   task automatic check_retirement();
      int k;
      k = ret_cnt;
      assert (o_wb_we === r_we[cur][k])
         else report_mismatch("o_wb_we", k, o_wb_we, r_we[cur][k]);
      assert (o_wb_pc === r_pc[cur][k])
         else report_mismatch("o_wb_pc", k, o_wb_pc, r_pc[cur][k]);
      if (r_we[cur][k]) begin
         assert (o_wb_sel === r_sel[cur][k])
            else report_mismatch("o_wb_sel", k, o_wb_sel, r_sel[cur][k]);
         assert (o_wb_data === r_data[cur][k])
            else report_mismatch("o_wb_data", k, o_wb_data, r_data[cur][k]);
      end
      if (r_gap[cur][k]) begin
         assert (cycle - last_ret > 1)
            else report_failure($sformatf("no stall cycle before retirement %0d", k));
      end
      last_ret = cycle;
      ret_cnt  = k + 1;
   endtask

   task automatic check_store();
      assert (st_cnt < n_st[cur]) else report_failure("a store happened that was not expected");
      if (st_cnt < n_st[cur]) begin
         assert (o_dmem_addr === s_addr[cur][st_cnt])
            else report_mismatch("o_dmem_addr", st_cnt, o_dmem_addr, s_addr[cur][st_cnt]);
         assert (o_dmem_towrite === s_data[cur][st_cnt])
            else report_mismatch("o_dmem_towrite", st_cnt, o_dmem_towrite, s_data[cur][st_cnt]);
      end
      st_cnt++;
   endtask

   // sample mid-cycle, the write lands after the compare
   always @(negedge gwe) begin
      cycle++;
      if (running && o_wb_valid === 1'b1) check_retirement();
      if (running && o_dmem_we === 1'b1) begin
         check_store();
         dmem[o_dmem_addr] = o_dmem_towrite;
      end
   end

   task automatic run_test(int t);
      int errs_before;
      errs_before = errors;
      cur      = t;
      ret_cnt  = 0;
      st_cnt   = 0;
      last_ret = cycle;
      @(posedge gwe);
      #2;
      i_reset = 1'b1;
      load_program(t);
      apply_reset();
      running = 1'b1;
      wait (ret_cnt == n_ret[t]);
      running = 1'b0;
      assert (st_cnt == n_st[t])
         else report_failure($sformatf("saw %0d stores, expected %0d", st_cnt, n_st[t]));
      if (errors > errs_before) failed++;
      $display("test %0d (%s): %0d retirements, %0d stores, %0d errors",
               t + 1, tname[t], ret_cnt, st_cnt, errors - errs_before);
   endtask

   // watchdog, four cycles per instruction plus slack
   initial begin
      wait (table_done);
      #((total_insn * 4 + 20) * 40);
      report_failure($sformatf("timeout after %0d of %0d retirements", ret_cnt, n_ret[cur]));
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      gwe        = 1'b0;
      i_reset    = 1'b1;
      running    = 1'b0;
      table_done = 1'b0;
      errors     = 0;
      failed     = 0;
      cycle      = 0;
      cur        = 0;
      ret_cnt    = 0;
      st_cnt     = 0;
      last_ret   = 0;
      void'($urandom(65));
      build_table();
      load_program(0);
      total_insn = 0;
      for (int t = 0; t < NTESTS; t++)
         total_insn += n_insn[t];
      table_done = 1'b1;
      for (int t = 0; t < NTESTS; t++)
         run_test(t);
      $display("%0d tests run, %0d failed, %0d errors", NTESTS, failed, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+hw
hw/lc4_pkg.sv
hw/lc4_stage_if.sv
hw/lc4_fetch.sv
hw/lc4_decoder.sv
hw/lc4_regfile.sv
hw/lc4_execute.sv
hw/lc4_memwb.sv
hw/lc4_hazard_ctrl.sv
hw/lc4_processor.sv
verification/lc4_tb.sv

// ==== Bender.yml ====
package:
  name: lc4_pipeline

sources:
  - include_dirs:
      - hw
    files:
      - hw/lc4_pkg.sv
      - hw/lc4_stage_if.sv
      - hw/lc4_fetch.sv
      - hw/lc4_decoder.sv
      - hw/lc4_regfile.sv
      - hw/lc4_execute.sv
      - hw/lc4_memwb.sv
      - hw/lc4_hazard_ctrl.sv
      - hw/lc4_processor.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/lc4_tb.sv
